// File: files.f
logic/dsp_pkg.sv
logic/delay_line.sv
logic/ffe_slicer.sv
logic/residual_error_est.sv
logic/error_flagger.sv
logic/dsp_datapath_top.sv
verif/tb_dsp_datapath.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_dsp_datapath
FLAGS     ?= --binary --timing -Wno-fatal
OBJ_DIR   ?= obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and look for the pass message"
	@echo "  clean  remove $(OBJ_DIR)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR, TOP, FLAGS, OBJ_DIR"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f files.f
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "TEST RESULT: PASS"

clean:
	rm -rf $(OBJ_DIR)

// File: verif/tb_dsp_datapath.sv
`timescale 1ns/1ps

module tb_dsp_datapath;

    localparam int lanes = dsp_pkg::num_lanes;
    // Checked words plus six flush words for each of seven configurations
    localparam int total_words = 16 + 100 + 200 + 3 * 40 + 200 + 7 * 6;

    typedef dsp_pkg::sym_t [lanes-1:0] sym_word_t;
    typedef dsp_pkg::err_t [lanes-1:0] err_word_t;
    typedef logic [lanes-1:0]          flag_word_t;

    typedef struct packed {
        int              due;
        sym_word_t       sym;
        err_word_t       err;
        flag_word_t      flags;
        dsp_pkg::count_t count;
    } expect_t;

    logic             clk;
    logic             rst_n;
    dsp_pkg::code_t   adc_codes   [lanes-1:0];
    dsp_pkg::weight_t ffe_weights [dsp_pkg::ffe_length-1:0];
    dsp_pkg::shift_t  ffe_shift;
    dsp_pkg::est_t    bit_level;
    dsp_pkg::weight_t chan_taps   [dsp_pkg::chan_length-1:0];
    dsp_pkg::shift_t  chan_shift;
    dsp_pkg::thresh_t err_thresh;
    dsp_pkg::sym_t    sym_out     [lanes-1:0];
    dsp_pkg::err_t    err_out     [lanes-1:0];
    logic             flags_out   [lanes-1:0];
    dsp_pkg::count_t  count_out;

    logic [31:0] lfsr      = 32'hfa2a;
    int          cycle_cnt = 0;
    int          code_hist [$];
    int          sym_hist  [$];
    expect_t     exp_q     [$];
    string       name_q    [$];

    dsp_datapath_top dut_i (
        .clk           (clk),
        .rst_n_i       (rst_n),
        .adc_codes_i   (adc_codes),
        .ffe_weights_i (ffe_weights),
        .ffe_shift_i   (ffe_shift),
        .bit_level_i   (bit_level),
        .chan_taps_i   (chan_taps),
        .chan_shift_i  (chan_shift),
        .err_thresh_i  (err_thresh),
        .sym_o         (sym_out),
        .res_err_o     (err_out),
        .flags_o       (flags_out),
        .flag_count_o  (count_out)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    // Galois LFSR stepped once per bit
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] bits;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            bits = {bits[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
        end
        return bits;
    endfunction

    function automatic int pam4_slice(input int est, input int level);
        if (est >= level) return 3;
        if (est >= 0) return 2;
        if (est >= -level) return 1;
        return 0;
    endfunction

    // Expected outputs for one word from the flat sample history
    function automatic expect_t model_word(input int codes [lanes]);
        expect_t e;
        int      base;
        int      acc;
        int      resid;
        base    = code_hist.size();
        e       = '0;
        for (int l = 0; l < lanes; l++) begin
            code_hist.push_back(codes[l]);
        end
        for (int l = 0; l < lanes; l++) begin
            acc = 0;
            for (int k = 0; k < dsp_pkg::ffe_length; k++) begin
                acc += int'(ffe_weights[k]) * code_hist[base + l - k];
            end
            sym_hist.push_back(pam4_slice(acc >>> ffe_shift, int'(bit_level)));
            e.sym[l] = dsp_pkg::sym_t'(sym_hist[base + l]);
        end
        for (int l = 0; l < lanes; l++) begin
            acc = 0;
            // PAM4 level is 2s - 3
            for (int k = 0; k < dsp_pkg::chan_length; k++) begin
                acc += int'(chan_taps[k]) * (2 * sym_hist[base + l - k] - 3);
            end
            resid      = codes[l] - (acc >>> chan_shift);
            e.err[l]   = dsp_pkg::err_t'(resid);
            e.flags[l] = ((resid < 0) ? -resid : resid) > int'(err_thresh);
            e.count    = e.count + dsp_pkg::count_t'(e.flags[l]);
        end
        return e;
    endfunction

    function automatic flag_word_t flag_vec();
        flag_word_t v;
        for (int l = 0; l < lanes; l++) begin
            v[l] = flags_out[l];
        end
        return v;
    endfunction

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("TEST RESULT: FAIL");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_sym(input string name, input dsp_pkg::sym_t exp,
                             input dsp_pkg::sym_t act);
        if (act !== exp) begin
            stop_on_error($sformatf("[FAIL] %s sym: expected %0d, actual %0d", name, exp, act));
        end
    endtask

    task automatic check_err(input string name, input dsp_pkg::err_t exp,
                             input dsp_pkg::err_t act);
        if (act !== exp) begin
            stop_on_error($sformatf("[FAIL] %s err: expected %0d, actual %0d", name, exp, act));
        end
    endtask

    task automatic check_flags(input string name, input flag_word_t exp, input flag_word_t act);
        if (act !== exp) begin
            stop_on_error($sformatf("[FAIL] %s flags: expected %b, actual %b", name, exp, act));
        end
    endtask

    task automatic check_count(input string name, input dsp_pkg::count_t exp,
                               input dsp_pkg::count_t act);
        if (act !== exp) begin
            stop_on_error($sformatf("[FAIL] %s count: expected %0d, actual %0d",
                                    name, exp, act));
        end
    endtask

    // All outputs at their reset value
    task automatic check_idle(input string name);
        for (int l = 0; l < lanes; l++) begin
            check_sym(name, '0, sym_out[l]);
            check_err(name, '0, err_out[l]);
        end
        check_flags(name, '0, flag_vec());
        check_count(name, '0, count_out);
    endtask

    task automatic drive_word(input string name, input bit check, input int codes [lanes]);
        expect_t e;
        for (int l = 0; l < lanes; l++) begin
            adc_codes[l] = dsp_pkg::code_t'(codes[l]);
        end
        e = model_word(codes);
        if (check) begin
            // Four rising edges from input to the outputs
            e.due = cycle_cnt + 4;
            exp_q.push_back(e);
            name_q.push_back(name);
        end
        @(negedge clk);
    endtask

    task automatic run_words(input string name, input int n, input bit check);
        int codes [lanes];
        for (int w = 0; w < n; w++) begin
            for (int l = 0; l < lanes; l++) begin
                codes[l] = int'(dsp_pkg::code_t'(take_bits(8)));
            end
            drive_word(name, check, codes);
        end
    endtask

    task automatic randomize_ffe();
        for (int k = 0; k < dsp_pkg::ffe_length; k++) begin
            ffe_weights[k] = dsp_pkg::weight_t'(take_bits(6));
        end
        ffe_shift = dsp_pkg::shift_t'(take_bits(2));
        bit_level = dsp_pkg::est_t'(take_bits(7));
    endtask

    task automatic randomize_chan();
        for (int k = 0; k < dsp_pkg::chan_length; k++) begin
            chan_taps[k] = dsp_pkg::weight_t'(take_bits(6));
        end
        chan_shift = dsp_pkg::shift_t'(take_bits(2));
    endtask

    always @(negedge clk) begin
        expect_t e;
        string   name;
        if (exp_q.size() != 0 && exp_q[0].due == cycle_cnt) begin
            e    = exp_q.pop_front();
            name = name_q.pop_front();
            for (int l = 0; l < lanes; l++) begin
                check_sym(name, e.sym[l], sym_out[l]);
                check_err(name, e.err[l], err_out[l]);
            end
            check_flags(name, e.flags, flag_vec());
            check_count(name, e.count, count_out);
        end
    end

    initial begin
        #((total_words + 20) * 10);
        stop_on_error("Watchdog timeout: the run went on longer than the tests need");
    end

    initial begin
        int table_codes [8];
        int codes [lanes];
        // Band edges for level 64
        table_codes = '{127, 64, 63, 0, -1, -64, -65, -128};
        rst_n = 1'b0;
        for (int l = 0; l < lanes; l++) begin
            adc_codes[l] = '0;
        end
        for (int k = 0; k < dsp_pkg::ffe_length; k++) begin
            ffe_weights[k] = (k == 0) ? 6'sd1 : 6'sd0;
        end
        ffe_shift  = '0;
        bit_level  = 16'sd64;
        err_thresh = 10'd100;
        randomize_chan();

        repeat (2) begin
            @(negedge clk);
            check_idle("reset");
        end
        rst_n = 1'b1;
        // Zero codes before release and their slicer decisions
        for (int k = 0; k < dsp_pkg::ffe_length - 1; k++) begin
            code_hist.push_back(0);
            sym_hist.push_back(pam4_slice(0, int'(bit_level)));
        end

        run_words("flush", 1, 1'b0);
        // Pipeline still holds reset contents one cycle after release
        check_idle("after_reset");
        run_words("flush", 1, 1'b0);
        for (int w = 0; w < 16; w++) begin
            for (int l = 0; l < lanes; l++) begin
                codes[l] = table_codes[(4 * w + l + w / 2) % 8];
            end
            drive_word("identity_slicer", 1'b1, codes);
        end
        run_words("flush", 4, 1'b0);

        randomize_ffe();
        run_words("flush", 2, 1'b0);
        run_words("ffe_history", 100, 1'b1);
        run_words("flush", 4, 1'b0);

        randomize_chan();
        run_words("flush", 2, 1'b0);
        run_words("residual_error", 200, 1'b1);
        run_words("flush", 4, 1'b0);

        for (int t = 0; t < 3; t++) begin
            err_thresh = (t == 0) ? 10'd0 : ((t == 1) ? 10'd50 : 10'd1023);
            run_words("flush", 2, 1'b0);
            run_words($sformatf("flags_thresh_%0d", err_thresh), 40, 1'b1);
            run_words("flush", 4, 1'b0);
        end

        randomize_ffe();
        randomize_chan();
        err_thresh = dsp_pkg::thresh_t'(take_bits(7));
        run_words("flush", 2, 1'b0);
        run_words("streaming", 200, 1'b1);
        run_words("flush", 4, 1'b0);

        while (exp_q.size() != 0) begin
            @(negedge clk);
        end
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

// File: logic/dsp_datapath_top.sv
`timescale 1ns/1ps

module dsp_datapath_top (
    input  logic             clk,
    input  logic             rst_n_i,
    input  dsp_pkg::code_t   adc_codes_i   [dsp_pkg::num_lanes-1:0],
    input  dsp_pkg::weight_t ffe_weights_i [dsp_pkg::ffe_length-1:0],
    input  dsp_pkg::shift_t  ffe_shift_i,
    input  dsp_pkg::est_t    bit_level_i,
    input  dsp_pkg::weight_t chan_taps_i   [dsp_pkg::chan_length-1:0],
    input  dsp_pkg::shift_t  chan_shift_i,
    input  dsp_pkg::thresh_t err_thresh_i,
    output dsp_pkg::sym_t    sym_o         [dsp_pkg::num_lanes-1:0],
    output dsp_pkg::err_t    res_err_o     [dsp_pkg::num_lanes-1:0],
    output logic             flags_o       [dsp_pkg::num_lanes-1:0],
    output dsp_pkg::count_t  flag_count_o
);

    localparam int lanes = dsp_pkg::num_lanes;

    // Decode stage outputs
    dsp_pkg::sym_t  dec_sym   [lanes-1:0];
    dsp_pkg::code_t dec_codes [lanes-1:0];

    // Execute stage outputs
    dsp_pkg::sym_t  exe_sym     [lanes-1:0];
    dsp_pkg::err_t  exe_res_err [lanes-1:0];

    ffe_slicer #(
        .lanes (lanes)
    ) dec_stage_i (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .codes_i     (adc_codes_i),
        .weights_i   (ffe_weights_i),
        .ffe_shift_i (ffe_shift_i),
        .bit_level_i (bit_level_i),
        .sym_o       (dec_sym),
        .codes_o     (dec_codes)
    );

    residual_error_est #(
        .lanes (lanes)
    ) exe_stage_i (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .sym_i        (dec_sym),
        .codes_i      (dec_codes),
        .chan_taps_i  (chan_taps_i),
        .chan_shift_i (chan_shift_i),
        .sym_o        (exe_sym),
        .res_err_o    (exe_res_err)
    );

    error_flagger #(
        .lanes (lanes)
    ) res_stage_i (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .res_err_i    (exe_res_err),
        .err_thresh_i (err_thresh_i),
        .flags_o      (flags_o),
        .flag_count_o (flag_count_o)
    );

    // One cycle each to match the result stage register
    delay_line #(
        .payload_t (dsp_pkg::sym_t),
        .lanes     (lanes),
        .depth     (1)
    ) sym_dly_i (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .data_i  (exe_sym),
        .data_o  (sym_o)
    );

    delay_line #(
        .payload_t (dsp_pkg::err_t),
        .lanes     (lanes),
        .depth     (1)
    ) err_dly_i (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .data_i  (exe_res_err),
        .data_o  (res_err_o)
    );

endmodule

// File: logic/error_flagger.sv
`timescale 1ns/1ps

module error_flagger #(
    parameter int lanes = dsp_pkg::num_lanes
) (
    input  logic             clk,
    input  logic             rst_n_i,
    input  dsp_pkg::err_t    res_err_i    [lanes-1:0],
    input  dsp_pkg::thresh_t err_thresh_i,
    output logic             flags_o      [lanes-1:0],
    output dsp_pkg::count_t  flag_count_o
);

    localparam int mag_w = $bits(dsp_pkg::err_t);

    logic [mag_w-1:0] mag    [lanes-1:0];
    logic             flag_d [lanes-1:0];
    dsp_pkg::count_t  count_d;

    // Magnitude is unsigned, so the most negative error still fits
    always_comb begin
        count_d = '0;
        for (int l = 0; l < lanes; l++) begin
            if (res_err_i[l] < 0) begin
                mag[l] = mag_w'(-res_err_i[l]);
            end else begin
                mag[l] = mag_w'(res_err_i[l]);
            end
            flag_d[l] = mag[l] > err_thresh_i;
            count_d   = count_d + dsp_pkg::count_t'(flag_d[l]);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            for (int l = 0; l < lanes; l++) begin
                flags_o[l] <= 1'b0;
            end
            flag_count_o <= '0;
        end else begin
            flags_o      <= flag_d;
            flag_count_o <= count_d;
        end
    end

endmodule

// File: logic/residual_error_est.sv
`timescale 1ns/1ps

module residual_error_est #(
    parameter int lanes = dsp_pkg::num_lanes
) (
    input  logic             clk,
    input  logic             rst_n_i,
    input  dsp_pkg::sym_t    sym_i        [lanes-1:0],
    input  dsp_pkg::code_t   codes_i      [lanes-1:0],
    input  dsp_pkg::weight_t chan_taps_i  [dsp_pkg::chan_length-1:0],
    input  dsp_pkg::shift_t  chan_shift_i,
    output dsp_pkg::sym_t    sym_o        [lanes-1:0],
    output dsp_pkg::err_t    res_err_o    [lanes-1:0]
);

    localparam int hist_len = dsp_pkg::chan_length - 1;

    dsp_pkg::sym_t hist_q    [hist_len-1:0];
    dsp_pkg::sym_t window    [lanes+hist_len-1:0];
    dsp_pkg::err_t res_err_d [lanes-1:0];

    // Symbol to PAM4 level: -3, -1, +1, +3
    function automatic dsp_pkg::err_t pam4_value(input dsp_pkg::sym_t s);
        return dsp_pkg::err_t'({1'b0, s}) * 2 - 3;
    endfunction

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            for (int h = 0; h < hist_len; h++) begin
                hist_q[h] <= '0;
            end
        end else begin
            for (int h = 0; h < hist_len; h++) begin
                hist_q[h] <= sym_i[lanes-hist_len+h];
            end
        end
    end

    always_comb begin
        for (int h = 0; h < hist_len; h++) begin
            window[h] = hist_q[h];
        end
        for (int l = 0; l < lanes; l++) begin
            window[hist_len+l] = sym_i[l];
        end
    end

    // Expected code from the channel estimate, then the leftover
    always_comb begin
        dsp_pkg::err_t acc;
        for (int l = 0; l < lanes; l++) begin
            acc = '0;
            for (int k = 0; k < dsp_pkg::chan_length; k++) begin
                acc = acc + pam4_value(window[hist_len+l-k])
                          * dsp_pkg::err_t'(chan_taps_i[k]);
            end
            res_err_d[l] = dsp_pkg::err_t'(codes_i[l]) - (acc >>> chan_shift_i);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            for (int l = 0; l < lanes; l++) begin
                sym_o[l]     <= '0;
                res_err_o[l] <= '0;
            end
        end else begin
            sym_o     <= sym_i;
            res_err_o <= res_err_d;
        end
    end

endmodule

// File: logic/ffe_slicer.sv
`timescale 1ns/1ps

module ffe_slicer #(
    parameter int lanes = dsp_pkg::num_lanes
) (
    input  logic             clk,
    input  logic             rst_n_i,
    input  dsp_pkg::code_t   codes_i     [lanes-1:0],
    input  dsp_pkg::weight_t weights_i   [dsp_pkg::ffe_length-1:0],
    input  dsp_pkg::shift_t  ffe_shift_i,
    input  dsp_pkg::est_t    bit_level_i,
    output dsp_pkg::sym_t    sym_o       [lanes-1:0],
    output dsp_pkg::code_t   codes_o     [lanes-1:0]
);

    localparam int hist_len = dsp_pkg::ffe_length - 1;

    dsp_pkg::code_t codes_q [lanes-1:0];
    dsp_pkg::code_t hist_q  [hist_len-1:0];
    // Oldest history first, then the current word
    dsp_pkg::code_t window  [lanes+hist_len-1:0];
    dsp_pkg::est_t  est     [lanes-1:0];
    dsp_pkg::sym_t  sym_d   [lanes-1:0];

    // Input register plus the tail of the previous word
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            for (int l = 0; l < lanes; l++) begin
                codes_q[l] <= '0;
            end
            for (int h = 0; h < hist_len; h++) begin
                hist_q[h] <= '0;
            end
        end else begin
            codes_q <= codes_i;
            for (int h = 0; h < hist_len; h++) begin
                hist_q[h] <= codes_q[lanes-hist_len+h];
            end
        end
    end

    always_comb begin
        for (int h = 0; h < hist_len; h++) begin
            window[h] = hist_q[h];
        end
        for (int l = 0; l < lanes; l++) begin
            window[hist_len+l] = codes_q[l];
        end
    end

    // Tap k looks k samples back
    always_comb begin
        dsp_pkg::est_t acc;
        for (int l = 0; l < lanes; l++) begin
            acc = '0;
            for (int k = 0; k < dsp_pkg::ffe_length; k++) begin
                acc = acc + dsp_pkg::est_t'(weights_i[k])
                          * dsp_pkg::est_t'(window[hist_len+l-k]);
            end
            est[l] = acc >>> ffe_shift_i;
        end
    end

    // PAM4 decision against +L, 0 and -L
    always_comb begin
        for (int l = 0; l < lanes; l++) begin
            if (est[l] >= bit_level_i) begin
                sym_d[l] = 2'd3;
            end else if (est[l] >= 0) begin
                sym_d[l] = 2'd2;
            end else if (est[l] >= -bit_level_i) begin
                sym_d[l] = 2'd1;
            end else begin
                sym_d[l] = 2'd0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            for (int l = 0; l < lanes; l++) begin
                sym_o[l]   <= '0;
                codes_o[l] <= '0;
            end
        end else begin
            sym_o   <= sym_d;
            codes_o <= codes_q;
        end
    end

endmodule

// File: logic/delay_line.sv
`timescale 1ns/1ps

module delay_line #(
    parameter type payload_t = logic,
    parameter int  lanes     = 1,
    parameter int  depth     = 1
) (
    input  logic     clk,
    input  logic     rst_n_i,
    input  payload_t data_i [lanes-1:0],
    output payload_t data_o [lanes-1:0]
);

    // Stage 0 is the newest
    payload_t stage_q [depth-1:0][lanes-1:0];

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            for (int d = 0; d < depth; d++) begin
                for (int l = 0; l < lanes; l++) begin
                    stage_q[d][l] <= '0;
                end
            end
        end else begin
            stage_q[0] <= data_i;
            for (int d = 1; d < depth; d++) begin
                stage_q[d] <= stage_q[d-1];
            end
        end
    end

    assign data_o = stage_q[depth-1];

endmodule

// File: logic/dsp_pkg.sv
package dsp_pkg;

    // Word and filter geometry
    localparam int num_lanes   = 4;
    localparam int ffe_length  = 3;
    localparam int chan_length = 3;

    // Raw ADC sample
    typedef logic signed [7:0] code_t;

    // FFE weight, also used for the channel estimate taps
    typedef logic signed [5:0] weight_t;

    // Equalized estimate, wide enough for a full three-tap sum
    typedef logic signed [15:0] est_t;

    // PAM4 symbol, 0 to 3
    typedef logic [1:0] sym_t;

    // Residual error after channel reconstruction
    typedef logic signed [10:0] err_t;

    typedef logic [3:0] shift_t;

    typedef logic [9:0] thresh_t;

    // Flagged lanes per word, 0 to 4
    typedef logic [2:0] count_t;

endpackage
